/* source/ctrl_params.svh */
`ifndef CTRL_PARAMS_SVH
`define CTRL_PARAMS_SVH

// Instruction field positions
`define COND_HI   31
`define COND_LO   28
`define OP_HI     27
`define OP_LO     26
`define IBIT      25
`define DPOP_HI   24
`define DPOP_LO   21
`define UBIT      23
`define BBIT      22
`define SBIT      20
`define LBIT      20
`define RD_HI     15
`define RD_LO     12

// Instruction classes in bits 27:26
`define CLASS_DP  2'b00
`define CLASS_MEM 2'b01
`define CLASS_BR  2'b10

// ALU operations used outside data processing
`define ALU_ADD   4'b0100
`define ALU_SUB   4'b0010

// Condition field encodings
`define COND_EQ   4'b0000
`define COND_NE   4'b0001
`define COND_CS   4'b0010
`define COND_CC   4'b0011
`define COND_MI   4'b0100
`define COND_PL   4'b0101
`define COND_VS   4'b0110
`define COND_VC   4'b0111
`define COND_HI_U 4'b1000
`define COND_LS   4'b1001
`define COND_GE   4'b1010
`define COND_LT   4'b1011
`define COND_GT   4'b1100
`define COND_LE   4'b1101
`define COND_AL   4'b1110

`define REG_PC    4'd15

`endif

/* source/ctrlPkg.sv */
package ctrlPkg;

  typedef logic [31:0] instrWord;
  typedef logic [3:0]  flagVec;   // N, Z, C, V from msb down
  typedef logic [3:0]  condCode;
  typedef logic [3:0]  aluCtrl;
  typedef logic [3:0]  byteMask;
  typedef logic [1:0]  byteOff;
  typedef logic [1:0]  flagWe;    // [1] NZ, [0] CV

  // Decode stage outputs
  typedef struct packed {
    logic [1:0] regSrc;
    logic [1:0] immSrc;
    logic       aluSrc;
    logic       memtoReg;
    logic       regWrite;
    logic       memWrite;
    logic       branch;
    logic       aluOp;
    logic       byteAccess;
    aluCtrl     aluControl;
    flagWe      flagWrite;
    logic       pcSrc;
  } decodeCtrl;

  // Execute stage register
  typedef struct packed {
    logic    aluSrc;
    logic    memtoReg;
    logic    regWrite;
    logic    memWrite;
    logic    branch;
    logic    aluOp;
    logic    byteAccess;
    aluCtrl  aluControl;
    flagWe   flagWrite;
    logic    pcSrc;
    condCode cond;
  } execCtrl;

  // Memory stage register, enables already gated by the condition
  typedef struct packed {
    logic    memWrite;
    logic    memtoReg;
    logic    regWrite;
    logic    pcSrc;
    byteMask byteMask;
    logic    byteAccess;
    byteOff  byteOffset;
  } memCtrl;

  // Writeback stage register
  typedef struct packed {
    logic   memtoReg;
    logic   regWrite;
    logic   pcSrc;
    logic   byteLoad;
    byteOff byteOffset;
  } wbCtrl;

endpackage

/* source/mainDecoder.sv */
`include "ctrl_params.svh"

module mainDecoder (
  input  ctrlPkg::instrWord  instrD,
  output ctrlPkg::decodeCtrl ctrlD
);

  logic [1:0]      regSrc;
  logic [1:0]      immSrc;
  logic            aluSrc;
  logic            memtoReg;
  logic            regWrite;
  logic            memWrite;
  logic            branch;
  logic            aluOp;
  logic            byteAccess;
  ctrlPkg::aluCtrl aluControl;
  ctrlPkg::flagWe  flagWrite;
  logic            pcSrc;

  // Class decode
  always_comb begin
    regSrc     = 2'b00;
    immSrc     = 2'b00;
    aluSrc     = 1'b0;
    memtoReg   = 1'b0;
    regWrite   = 1'b0;
    memWrite   = 1'b0;
    branch     = 1'b0;
    aluOp      = 1'b0;
    byteAccess = 1'b0;
    case (instrD[`OP_HI:`OP_LO])
      `CLASS_DP: begin
        aluSrc   = instrD[`IBIT];  // Immediate operand 2
        regWrite = 1'b1;
        aluOp    = 1'b1;
      end
      `CLASS_MEM: begin
        immSrc     = 2'b01;          // 12-bit offset
        aluSrc     = ~instrD[`IBIT]; // I clear selects the immediate offset
        byteAccess = instrD[`BBIT];
        if (instrD[`LBIT]) begin     // LDR
          memtoReg = 1'b1;
          regWrite = 1'b1;
        end else begin               // STR reads Rd as data
          regSrc   = 2'b10;
          memWrite = 1'b1;
        end
      end
      `CLASS_BR: begin
        regSrc = 2'b01;              // PC as first source
        immSrc = 2'b10;              // 24-bit branch offset
        aluSrc = 1'b1;
        branch = 1'b1;
      end
      default: begin
        // Class 11 is a no-op
        regSrc = 2'b00;
      end
    endcase
  end

  // ALU control and flag enables
  always_comb begin
    if (aluOp) begin
      aluControl = instrD[`DPOP_HI:`DPOP_LO];
      flagWrite  = {2{instrD[`SBIT]}};
    end else if (instrD[`OP_HI:`OP_LO] == `CLASS_MEM) begin
      aluControl = instrD[`UBIT] ? `ALU_ADD : `ALU_SUB; // Offset sign
      flagWrite  = 2'b00;
    end else if (branch) begin
      aluControl = `ALU_ADD; // PC plus offset
      flagWrite  = 2'b00;
    end else begin
      aluControl = 4'b0000;
      flagWrite  = 2'b00;
    end
  end

  // Branches and writes to r15 redirect fetch
  assign pcSrc = branch | (regWrite & (instrD[`RD_HI:`RD_LO] == `REG_PC));

  assign ctrlD = '{
    regSrc:     regSrc,
    immSrc:     immSrc,
    aluSrc:     aluSrc,
    memtoReg:   memtoReg,
    regWrite:   regWrite,
    memWrite:   memWrite,
    branch:     branch,
    aluOp:      aluOp,
    byteAccess: byteAccess,
    aluControl: aluControl,
    flagWrite:  flagWrite,
    pcSrc:      pcSrc
  };

endmodule

/* source/condUnit.sv */
`include "ctrl_params.svh"

module condUnit (
  input  logic             clk,
  input  logic             rstN,
  input  logic             stallE,
  input  ctrlPkg::condCode condE,
  input  ctrlPkg::flagWe   flagWriteE,
  input  ctrlPkg::flagVec  aluFlagsE,
  output logic             condExE,
  output ctrlPkg::flagVec  flagsE
);

  logic n;
  logic z;
  logic c;
  logic v;

  assign {n, z, c, v} = flagsE;

  // Condition check against the held flags
  always_comb begin
    case (condE)
      `COND_EQ:   condExE = z;
      `COND_NE:   condExE = ~z;
      `COND_CS:   condExE = c;
      `COND_CC:   condExE = ~c;
      `COND_MI:   condExE = n;
      `COND_PL:   condExE = ~n;
      `COND_VS:   condExE = v;
      `COND_VC:   condExE = ~v;
      `COND_HI_U: condExE = c & ~z;       // Unsigned higher
      `COND_LS:   condExE = ~c | z;
      `COND_GE:   condExE = (n == v);
      `COND_LT:   condExE = (n != v);
      `COND_GT:   condExE = ~z & (n == v);
      `COND_LE:   condExE = z | (n != v);
      `COND_AL:   condExE = 1'b1;
      default:    condExE = 1'b1;         // 1111 runs as always
    endcase
  end

  // NZCV register
  // Each half loads under its own enable, only for a passing instruction
  always_ff @(posedge clk) begin
    if (!rstN) begin
      flagsE <= '0;
    end else if (!stallE && condExE) begin
      if (flagWriteE[1]) begin
        flagsE[3:2] <= aluFlagsE[3:2]; // N, Z
      end
      if (flagWriteE[0]) begin
        flagsE[1:0] <= aluFlagsE[1:0]; // C, V
      end
    end
  end

endmodule

/* source/memoryMask.sv */
module memoryMask (
  input  logic             byteAccess,
  input  ctrlPkg::byteOff  addrLow,
  output ctrlPkg::byteMask mask
);

  ctrlPkg::byteMask laneSel;

  // One-hot lane for a byte access, lane 0 is the low byte
  always_comb begin
    case (addrLow)
      2'd0:    laneSel = 4'b0001;
      2'd1:    laneSel = 4'b0010;
      2'd2:    laneSel = 4'b0100;
      default: laneSel = 4'b1000;
    endcase
  end

  // Word accesses use every lane
  assign mask = byteAccess ? laneSel : 4'b1111;

endmodule

/* source/controller.sv */
`include "ctrl_params.svh"

module controller (
  input  logic              clk,
  input  logic              rstN,
  input  ctrlPkg::instrWord instrD,
  input  ctrlPkg::flagVec   aluFlagsE,
  input  ctrlPkg::byteOff   addrLowE,
  input  logic              stallE,
  input  logic              flushE,
  input  logic              stallM,
  input  logic              stallW,
  input  logic              flushW,
  output logic [1:0]        regSrcD,
  output logic [1:0]        immSrcD,
  output logic              aluSrcE,
  output logic              memtoRegE,
  output logic              branchTakenE,
  output ctrlPkg::aluCtrl   aluControlE,
  output logic              memWriteM,
  output logic              memtoRegM,
  output logic              regWriteM,
  output ctrlPkg::byteMask  byteMaskM,
  output logic              memtoRegW,
  output logic              regWriteW,
  output logic              pcSrcW,
  output logic              byteLoadW,
  output ctrlPkg::byteOff   byteOffsetW,
  output logic              pcWrPendingF
);

  ctrlPkg::decodeCtrl ctrlD;
  ctrlPkg::execCtrl   nextE;
  ctrlPkg::execCtrl   ctrlE;
  ctrlPkg::memCtrl    nextM;
  ctrlPkg::memCtrl    ctrlM;
  ctrlPkg::wbCtrl     nextW;
  ctrlPkg::wbCtrl     ctrlW;
  ctrlPkg::byteMask   maskE;
  ctrlPkg::flagVec    flagsE; // Current NZCV
  logic               condExE;
  logic               noWriteE;

  // ==================================================
  // Decode
  // ==================================================
  mainDecoder decoder (
    .instrD (instrD),
    .ctrlD  (ctrlD)
  );

  assign regSrcD = ctrlD.regSrc;
  assign immSrcD = ctrlD.immSrc;

  assign nextE = '{
    aluSrc:     ctrlD.aluSrc,
    memtoReg:   ctrlD.memtoReg,
    regWrite:   ctrlD.regWrite,
    memWrite:   ctrlD.memWrite,
    branch:     ctrlD.branch,
    aluOp:      ctrlD.aluOp,
    byteAccess: ctrlD.byteAccess,
    aluControl: ctrlD.aluControl,
    flagWrite:  ctrlD.flagWrite,
    pcSrc:      ctrlD.pcSrc,
    cond:       instrD[`COND_HI:`COND_LO]
  };

  // ==================================================
  // Execute
  // ==================================================
  always_ff @(posedge clk) begin
    if (!rstN || flushE) begin // Flush wins over stall
      ctrlE <= '0;
    end else if (!stallE) begin
      ctrlE <= nextE;
    end
  end

  condUnit cond (
    .clk        (clk),
    .rstN       (rstN),
    .stallE     (stallE),
    .condE      (ctrlE.cond),
    .flagWriteE (ctrlE.flagWrite),
    .aluFlagsE  (aluFlagsE),
    .condExE    (condExE),
    .flagsE     (flagsE)
  );

  // TST, TEQ, CMP and CMN only set flags
  assign noWriteE = ctrlE.aluOp & (ctrlE.aluControl[3:2] == 2'b10);

  memoryMask byteLanes (
    .byteAccess (ctrlE.byteAccess),
    .addrLow    (addrLowE),
    .mask       (maskE)
  );

  assign aluSrcE      = ctrlE.aluSrc;
  assign memtoRegE    = ctrlE.memtoReg;
  assign aluControlE  = ctrlE.aluControl;
  assign branchTakenE = ctrlE.branch & condExE;

  assign nextM = '{
    memWrite:   ctrlE.memWrite & condExE,
    memtoReg:   ctrlE.memtoReg,
    regWrite:   ctrlE.regWrite & condExE & ~noWriteE,
    pcSrc:      ctrlE.pcSrc & condExE,
    byteMask:   maskE,
    byteAccess: ctrlE.byteAccess,
    byteOffset: addrLowE
  };

  // ==================================================
  // Memory
  // ==================================================
  always_ff @(posedge clk) begin
    if (!rstN) begin
      ctrlM <= '0;
    end else if (!stallM) begin
      ctrlM <= nextM;
    end
  end

  assign memWriteM = ctrlM.memWrite;
  assign memtoRegM = ctrlM.memtoReg;
  assign regWriteM = ctrlM.regWrite;
  assign byteMaskM = ctrlM.byteMask;

  assign nextW = '{
    memtoReg:   ctrlM.memtoReg,
    regWrite:   ctrlM.regWrite,
    pcSrc:      ctrlM.pcSrc,
    byteLoad:   ctrlM.byteAccess & ctrlM.memtoReg, // LDRB only
    byteOffset: ctrlM.byteOffset
  };

  // ==================================================
  // Writeback
  // ==================================================
  always_ff @(posedge clk) begin
    if (!rstN || flushW) begin
      ctrlW <= '0;
    end else if (!stallW) begin
      ctrlW <= nextW;
    end
  end

  assign memtoRegW   = ctrlW.memtoReg;
  assign regWriteW   = ctrlW.regWrite;
  assign pcSrcW      = ctrlW.pcSrc;
  assign byteLoadW   = ctrlW.byteLoad;
  assign byteOffsetW = ctrlW.byteOffset;

  // Any PC write still in flight holds fetch
  assign pcWrPendingF = ctrlD.pcSrc | ctrlE.pcSrc | ctrlM.pcSrc;

endmodule

/* test/controller_assertions.sv */
module controller_assertions (
  input logic             clk,
  input logic             rstN,
  input ctrlPkg::execCtrl ctrlE,
  input ctrlPkg::memCtrl  ctrlM,
  input logic             regWriteW,
  input logic             pcSrcW,
  input logic             pcWrPendingF
);

  int assertFails = 0; // Read by the testbench at the end of the run

  // Reset empties M and W of any write
  noWriteInReset: assert property (@(posedge clk)
    !rstN |=> !ctrlM.memWrite && !ctrlM.regWrite && !regWriteW && !pcSrcW)
  else begin
    assertFails++;
    $error("write enable left in M or W after a reset cycle");
  end

  // Memory access uses one lane or the whole word
  maskShape: assert property (@(posedge clk) disable iff (!rstN)
    (ctrlM.memWrite || ctrlM.memtoReg) |->
      ($onehot(ctrlM.byteMask) || ctrlM.byteMask == 4'b1111))
  else begin
    assertFails++;
    $error("byteMaskM is neither one lane nor all four");
  end

  pcPending: assert property (@(posedge clk) disable iff (!rstN)
    ctrlE.pcSrc |-> pcWrPendingF)
  else begin
    assertFails++;
    $error("pcWrPendingF low with a PC write in Execute");
  end

endmodule

/* test/controllerTb.sv */
`include "ctrl_params.svh"

module controllerTb;

  typedef struct packed {
    logic stallE;
    logic flushE;
    logic stallM;
    logic stallW;
    logic flushW;
  } hazardSet;

  localparam int resetCycles  = 16;
  localparam int decodeCycles = 40;  // Per class
  localparam int condCycles   = 300;
  localparam int maskCycles   = 200;
  localparam int stallCycles  = 300;
  localparam int pcCycles     = 200;
  localparam int resetRun     = 150;
  localparam int totalCycles  = resetCycles + 4 * decodeCycles + condCycles + maskCycles
                                + stallCycles + pcCycles + resetRun;
  localparam int timeLimit    = totalCycles * 8 + 800;

  logic              clk;
  logic              rstN;
  ctrlPkg::instrWord instrD;
  ctrlPkg::flagVec   aluFlagsE;
  ctrlPkg::byteOff   addrLowE;
  logic              stallE;
  logic              flushE;
  logic              stallM;
  logic              stallW;
  logic              flushW;
  logic [1:0]        regSrcD;
  logic [1:0]        immSrcD;
  logic              aluSrcE;
  logic              memtoRegE;
  logic              branchTakenE;
  ctrlPkg::aluCtrl   aluControlE;
  logic              memWriteM;
  logic              memtoRegM;
  logic              regWriteM;
  ctrlPkg::byteMask  byteMaskM;
  logic              memtoRegW;
  logic              regWriteW;
  logic              pcSrcW;
  logic              byteLoadW;
  ctrlPkg::byteOff   byteOffsetW;
  logic              pcWrPendingF;

  // Reference stage state
  ctrlPkg::execCtrl mE;
  ctrlPkg::memCtrl  mM;
  ctrlPkg::wbCtrl   mW;
  ctrlPkg::flagVec  mFlags;

  int checkCount  = 0;
  int errCount    = 0;
  int testsRun    = 0;
  int testsFailed = 0;
  int errBase     = 0;
  int checkBase   = 0;

  controller dut (.*);

  bind controller controller_assertions protocolChecks (
    .clk          (clk),
    .rstN         (rstN),
    .ctrlE        (ctrlE),
    .ctrlM        (ctrlM),
    .regWriteW    (regWriteW),
    .pcSrcW       (pcSrcW),
    .pcWrPendingF (pcWrPendingF)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  initial begin
    #(timeLimit);
    $display("Timeout: the run did not finish within %0d time units", timeLimit);
    $display("Some tests failed");
    $finish;
  end

  // ==================================================
  // Reference model
  // ==================================================
  function automatic ctrlPkg::decodeCtrl expectedDecode(input ctrlPkg::instrWord w);
    ctrlPkg::decodeCtrl d;
    d = '0;
    case (w[`OP_HI:`OP_LO])
      `CLASS_DP: begin
        d.aluSrc     = w[`IBIT];
        d.regWrite   = 1'b1;
        d.aluOp      = 1'b1;
        d.aluControl = w[`DPOP_HI:`DPOP_LO];
        d.flagWrite  = {2{w[`SBIT]}};
      end
      `CLASS_MEM: begin
        d.immSrc     = 2'b01;
        d.aluSrc     = ~w[`IBIT];
        d.byteAccess = w[`BBIT];
        d.aluControl = w[`UBIT] ? `ALU_ADD : `ALU_SUB;
        d.memtoReg   = w[`LBIT];
        d.regWrite   = w[`LBIT];
        d.memWrite   = ~w[`LBIT];
        d.regSrc     = w[`LBIT] ? 2'b00 : 2'b10;
      end
      `CLASS_BR: begin
        d.regSrc     = 2'b01;
        d.immSrc     = 2'b10;
        d.aluSrc     = 1'b1;
        d.branch     = 1'b1;
        d.aluControl = `ALU_ADD;
      end
      default: d = '0; // Class 11 does nothing
    endcase
    d.pcSrc = d.branch | (d.regWrite & (w[`RD_HI:`RD_LO] == `REG_PC));
    return d;
  endfunction

  // ARM pairs: odd codes invert the even one
  function automatic logic conditionHolds(input ctrlPkg::condCode c, input ctrlPkg::flagVec f);
    logic base;
    case (c[3:1])
      3'd0: base = f[2];
      3'd1: base = f[1];
      3'd2: base = f[3];
      3'd3: base = f[0];
      3'd4: base = f[1] & ~f[2];
      3'd5: base = (f[3] == f[0]);
      3'd6: base = ~f[2] & (f[3] == f[0]);
      default: base = 1'b1;
    endcase
    return (c[3:1] == 3'd7) ? 1'b1 : (base ^ c[0]);
  endfunction

  task automatic advanceModel;
    ctrlPkg::decodeCtrl d;
    ctrlPkg::memCtrl    nM;
    ctrlPkg::wbCtrl     nW;
    logic               pass;
    logic               compareOp;
    d         = expectedDecode(instrD);
    pass      = conditionHolds(mE.cond, mFlags);
    compareOp = mE.aluOp && (mE.aluControl[3:2] == 2'b10);
    nM.memWrite   = mE.memWrite & pass;
    nM.memtoReg   = mE.memtoReg;
    nM.regWrite   = mE.regWrite & pass & ~compareOp;
    nM.pcSrc      = mE.pcSrc & pass;
    nM.byteMask   = mE.byteAccess ? (4'b0001 << addrLowE) : 4'b1111;
    nM.byteAccess = mE.byteAccess;
    nM.byteOffset = addrLowE;
    nW.memtoReg   = mM.memtoReg;
    nW.regWrite   = mM.regWrite;
    nW.pcSrc      = mM.pcSrc;
    nW.byteLoad   = mM.byteAccess & mM.memtoReg;
    nW.byteOffset = mM.byteOffset;
    if (!rstN) begin
      mE     = '0;
      mM     = '0;
      mW     = '0;
      mFlags = '0;
    end else begin
      if (!stallE && pass && mE.flagWrite[1]) mFlags[3:2] = aluFlagsE[3:2];
      if (!stallE && pass && mE.flagWrite[0]) mFlags[1:0] = aluFlagsE[1:0];
      if (flushE) begin
        mE = '0;
      end else if (!stallE) begin
        mE = '{aluSrc: d.aluSrc, memtoReg: d.memtoReg, regWrite: d.regWrite,
               memWrite: d.memWrite, branch: d.branch, aluOp: d.aluOp,
               byteAccess: d.byteAccess, aluControl: d.aluControl,
               flagWrite: d.flagWrite, pcSrc: d.pcSrc, cond: instrD[`COND_HI:`COND_LO]};
      end
      if (!stallM) mM = nM;
      if (flushW) mW = '0;
      else if (!stallW) mW = nW;
    end
  endtask

  // ==================================================
  // Checking and stimulus
  // ==================================================
  task automatic checkEq(input logic [31:0] actual, input logic [31:0] expected,
                         input string what);
    checkCount++;
    if (actual !== expected) begin
      errCount++;
      $display("mismatch at %0t: %s is %h, expected %h", $time, what, actual, expected);
    end
  endtask

  task automatic compareOutputs;
    ctrlPkg::decodeCtrl d;
    d = expectedDecode(instrD);
    checkEq(regSrcD, d.regSrc, "regSrcD");
    checkEq(immSrcD, d.immSrc, "immSrcD");
    checkEq(aluSrcE, mE.aluSrc, "aluSrcE");
    checkEq(memtoRegE, mE.memtoReg, "memtoRegE");
    checkEq(aluControlE, mE.aluControl, "aluControlE");
    checkEq(branchTakenE, mE.branch & conditionHolds(mE.cond, mFlags), "branchTakenE");
    checkEq(memWriteM, mM.memWrite, "memWriteM");
    checkEq(memtoRegM, mM.memtoReg, "memtoRegM");
    checkEq(regWriteM, mM.regWrite, "regWriteM");
    checkEq(byteMaskM, mM.byteMask, "byteMaskM");
    checkEq(memtoRegW, mW.memtoReg, "memtoRegW");
    checkEq(regWriteW, mW.regWrite, "regWriteW");
    checkEq(pcSrcW, mW.pcSrc, "pcSrcW");
    checkEq(byteLoadW, mW.byteLoad, "byteLoadW");
    checkEq(byteOffsetW, mW.byteOffset, "byteOffsetW");
    checkEq(pcWrPendingF, d.pcSrc | mE.pcSrc | mM.pcSrc, "pcWrPendingF");
    checkEq(dut.flagsE, mFlags, "flags");
  endtask

  // Model steps on the edge, new inputs 1 unit later, compare once settled
  task automatic runCycle(input ctrlPkg::instrWord instr, input logic rstLevel,
                          input hazardSet hz);
    @(posedge clk);
    advanceModel();
    #1;
    rstN      = rstLevel;
    instrD    = instr;
    aluFlagsE = $urandom;
    addrLowE  = $urandom;
    stallE    = hz.stallE;
    flushE    = hz.flushE;
    stallM    = hz.stallM;
    stallW    = hz.stallW;
    flushW    = hz.flushW;
    #1;
    compareOutputs();
  endtask

  // cls 4 picks any class
  function automatic ctrlPkg::instrWord randomInstr(input int cls, input bit pcDest);
    ctrlPkg::instrWord w;
    w = $urandom;
    if (cls < 4) w[`OP_HI:`OP_LO] = cls[1:0];
    if (w[`OP_HI:`OP_LO] == `CLASS_DP && $urandom_range(2) == 0) begin
      w[24:23] = 2'b10; // TST, TEQ, CMP, CMN
    end
    if (pcDest || $urandom_range(7) == 0) w[`RD_HI:`RD_LO] = `REG_PC;
    return w;
  endfunction

  // Earlier stall always stalls the later stages too
  function automatic hazardSet pickHazards();
    hazardSet h;
    h.stallE = ($urandom_range(4) == 0);
    h.stallM = h.stallE | ($urandom_range(9) == 0);
    h.stallW = h.stallM | ($urandom_range(9) == 0);
    h.flushE = ($urandom_range(9) == 0);
    h.flushW = ($urandom_range(19) == 0);
    return h;
  endfunction

  task automatic startTest;
    errBase   = errCount;
    checkBase = checkCount;
  endtask

  task automatic endTest(input string name);
    testsRun++;
    if (errCount != errBase) testsFailed++;
    $display("test %-10s %0d checks, %0d mismatches", name, checkCount - checkBase,
             errCount - errBase);
  endtask

  // ==================================================
  // Test sequence
  // ==================================================
  initial begin
    int resetLeft;
    int sinceReset;
    logic rstLevel;
    void'($urandom(74788));
    rstN = 1'b0;
    instrD = '0;
    aluFlagsE = '0;
    addrLowE = '0;
    stallE = 1'b0;
    flushE = 1'b0;
    stallM = 1'b0;
    stallW = 1'b0;
    flushW = 1'b0;
    mE = '0;
    mM = '0;
    mW = '0;
    mFlags = '0;
    for (int i = 0; i < resetCycles; i++) runCycle('0, 1'b0, '0);

    startTest();
    for (int c = 0; c < 4; c++) begin
      for (int i = 0; i < decodeCycles; i++) runCycle(randomInstr(c, 1'b0), 1'b1, '0);
    end
    endTest("decode");

    startTest();
    for (int i = 0; i < condCycles; i++) begin
      runCycle(randomInstr(($urandom_range(3) == 0) ? 4 : 0, 1'b0), 1'b1, '0);
    end
    endTest("condition");

    startTest();
    for (int i = 0; i < maskCycles; i++) runCycle(randomInstr(1, 1'b0), 1'b1, '0);
    endTest("bytemask");

    startTest();
    for (int i = 0; i < stallCycles; i++) runCycle(randomInstr(4, 1'b0), 1'b1, pickHazards());
    endTest("stall");

    startTest();
    for (int i = 0; i < pcCycles; i++) begin
      runCycle(randomInstr($urandom_range(1) ? 2 : 0, $urandom_range(1)), 1'b1, '0);
    end
    endTest("pcpending");

    startTest();
    resetLeft  = 0;
    sinceReset = 100;
    for (int i = 0; i < resetRun; i++) begin
      if (resetLeft == 0 && $urandom_range(19) == 0) resetLeft = $urandom_range(1, 4);
      rstLevel = (resetLeft == 0);
      if (resetLeft > 0) resetLeft--;
      sinceReset = rstLevel ? sinceReset + 1 : 0;
      runCycle(randomInstr(4, 1'b0), rstLevel, pickHazards());
      if (sinceReset == 2) checkEq(dut.flagsE, 4'b0000, "flags after reset");
    end
    endTest("reset");

    $display("tests run %0d, failed %0d, checks %0d, mismatches %0d, assertion failures %0d",
             testsRun, testsFailed, checkCount, errCount, dut.protocolChecks.assertFails);
    if (errCount == 0 && dut.protocolChecks.assertFails == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

/* src.f */
+incdir+source
source/ctrlPkg.sv
source/mainDecoder.sv
source/condUnit.sv
source/memoryMask.sv
source/controller.sv
test/controller_assertions.sv
test/controllerTb.sv
